//--- fitness_trainer.f
hw/fitness_pkg.sv
hw/button_cond.sv
hw/tick_gen.sv
hw/workout_count.sv
hw/workout_seq.sv
hw/beep_gen.sv
hw/fitness_top.sv
verification/fitness_chk.sv
verification/fitness_tb.sv

//--- verification/fitness_tb.sv
// Testbench for fitness_top with shortened tick, debounce and beep timing.
// Buzzer activity is judged in bursts; gaps under half a beep unit are merged.
// No setting maps to a zero count with the current base table.
`default_nettype none

module fitness_tb
    import fitness_pkg::*;
();
    localparam int unsigned clk_period    = 20;
    localparam int unsigned tb_tick       = 400;
    localparam int unsigned tb_debounce   = 4;
    localparam int unsigned tb_beep_unit  = 20;
    localparam int unsigned tb_tone_div   = 3;
    localparam int unsigned triple_cycles = 5 * tb_beep_unit + 20;
    localparam int unsigned long_cycles   = long_beep_units * tb_beep_unit + 20;
    localparam int unsigned press_limit   = 30;
    localparam int unsigned btn_start     = 0;
    localparam int unsigned btn_skip      = 1;
    localparam int unsigned btn_cancel    = 2;
    // Ticks spent by tests 2 to 5 including the full exercise and rest periods
    localparam int unsigned test_ticks    = 2 + exercise_secs + rest_secs + 8;
    localparam int unsigned watchdog_time = 20 * test_ticks * tb_tick * clk_period;

    logic        clk;
    logic        rst;
    logic        start_n;
    logic        skip_n;
    logic        cancel_n;
    settings_t   settings;
    count_t      count;
    seq_status_t status;
    logic        buzzer;

    string       chk_name[$];
    logic [31:0] chk_exp[$];
    logic [31:0] chk_act[$];

    int cyc         = 0;
    int last_high   = -1000000;
    int burst_start = 0;
    int burst_count = 0;
    int max_burst   = 0;

    fitness_top #(
        .tick_cycles     (tb_tick),
        .debounce_cycles (tb_debounce),
        .beep_unit       (tb_beep_unit),
        .tone_div        (tb_tone_div)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .start_n_i  (start_n),
        .skip_n_i   (skip_n),
        .cancel_n_i (cancel_n),
        .settings_i (settings),
        .count_o    (count),
        .status_o   (status),
        .buzzer_o   (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected count from the base table and the scaling rule
    function automatic count_t expected_count(input settings_t s);
        int unsigned total;
        total = base_count_table[{s.weight, s.calories}];
        if (s.female) begin
            total = total + total / 8;
        end
        return count_t'(total >> s.met);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        chk_name.push_back(name);
        chk_exp.push_back(exp);
        chk_act.push_back(act);
    endtask

    task automatic press_button(input int unsigned which);
        @(posedge clk);
        #2;
        case (which)
            btn_start: start_n  = 1'b0;
            btn_skip:  skip_n   = 1'b0;
            default:   cancel_n = 1'b0;
        endcase
        repeat (10) @(posedge clk);
        #2;
        start_n  = 1'b1;
        skip_n   = 1'b1;
        cancel_n = 1'b1;
        repeat (tb_debounce + 4) @(posedge clk);  // Let the release settle
    endtask

    task automatic wait_for_state(input phase_t phase, input count_t index,
                                  input int unsigned limit, input string what);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while ((status.phase != phase || status.index != index) && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (status.phase == phase && status.index == index)
            else fail_run($sformatf("Timed out waiting for %s", what));
    endtask

    // One tick in exercise lowers the timer to exp_timer
    task automatic wait_for_tick(input secs_t exp_timer);
        secs_t       old_timer;
        int unsigned n;
        old_timer = status.timer;
        n = 0;
        @(negedge clk);
        while (status.timer == old_timer && n < tb_tick + 10) begin
            @(negedge clk);
            n++;
        end
        assert (status.timer != old_timer) else fail_run("No tick seen within one tick period");
        check_value("status_o.timer", exp_timer, status.timer);
    endtask

    task automatic clear_bursts();
        burst_count = 0;
        max_burst   = 0;
        last_high   = -1000000;
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (buzzer === 1'b1) begin
            if (cyc - last_high > tb_beep_unit / 2) begin
                burst_count = burst_count + 1;
                burst_start = cyc;
            end
            last_high = cyc;
            if (cyc - burst_start + 1 > max_burst) begin
                max_burst = cyc - burst_start + 1;
            end
        end
    end

    initial begin : compare
        string       name;
        logic [31:0] exp_v;
        logic [31:0] act_v;
        forever begin
            @(negedge clk);
            while (chk_name.size() > 0) begin
                name  = chk_name.pop_front();
                exp_v = chk_exp.pop_front();
                act_v = chk_act.pop_front();
                assert (act_v === exp_v)
                    else fail_run($sformatf("Error: %s expected 0x%0h, got 0x%0h",
                                            name, exp_v, act_v));
            end
        end
    end

    initial begin : watchdog
        #(watchdog_time);
        fail_run("Watchdog expired before all tests completed");
    end

    initial begin : stimulus
        logic [31:0] rnd;
        settings_t   small_settings;
        settings_t   zero_settings;
        count_t      session_len;
        count_t      idx;
        bit          zero_found;
        rst            = 1'b1;
        start_n        = 1'b1;
        skip_n         = 1'b1;
        cancel_n       = 1'b1;
        settings       = '0;
        rnd            = 32'ha011fa5d;
        small_settings = '{weight: 3'd7, calories: 2'd0, met: 2'd3, female: 1'b0};
        zero_settings  = '0;
        zero_found     = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        // Count calculation over random settings
        repeat (40) begin
            rnd = xorshift(rnd);
            @(posedge clk);
            #2;
            settings = rnd[7:0];
            @(posedge clk);
            @(negedge clk);
            check_value("count_o", expected_count(settings), count);
        end

        // Start press and timer countdown
        session_len = expected_count(small_settings);
        @(posedge clk);
        #2;
        settings = small_settings;
        @(posedge clk);
        @(negedge clk);
        check_value("count_o", session_len, count);
        fork
            press_button(btn_start);
            begin
                wait_for_state(phase_exercise, '0, press_limit, "exercise after start");
                check_value("status_o.timer", exercise_secs, status.timer);
            end
        join
        wait_for_tick(exercise_secs - secs_t'(1));
        wait_for_tick(exercise_secs - secs_t'(2));

        // Full exercise and rest periods end with a triple beep each
        wait_for_state(phase_rest, '0, (exercise_secs + 1) * tb_tick, "rest period");
        clear_bursts();
        check_value("status_o.timer", rest_secs, status.timer);
        repeat (triple_cycles) @(negedge clk);
        check_value("buzzer_o bursts", 3, burst_count);
        wait_for_state(phase_exercise, 1, (rest_secs + 1) * tb_tick, "second exercise");
        clear_bursts();
        check_value("status_o.timer", exercise_secs, status.timer);
        repeat (triple_cycles) @(negedge clk);
        check_value("buzzer_o bursts", 3, burst_count);

        // Skip presses land just after a tick so that none coincides with one
        idx = count_t'(1);
        while (idx < session_len - count_t'(1)) begin
            wait_for_tick(exercise_secs - secs_t'(1));
            clear_bursts();
            fork
                press_button(btn_skip);
                wait_for_state(phase_exercise, idx + count_t'(1), press_limit, "skip");
            join
            repeat (triple_cycles) @(negedge clk);
            check_value("buzzer_o bursts", 3, burst_count);
            idx = idx + count_t'(1);
        end
        wait_for_tick(exercise_secs - secs_t'(1));
        clear_bursts();
        fork
            press_button(btn_skip);
            wait_for_state(phase_idle, '0, press_limit, "idle after last skip");
        join
        repeat (long_cycles) @(negedge clk);
        check_value("buzzer_o bursts", 1, burst_count);
        check_value("buzzer_o burst over 3 units", 1, max_burst > 3 * tb_beep_unit);

        // Cancel is silent
        clear_bursts();
        fork
            press_button(btn_start);
            wait_for_state(phase_exercise, '0, press_limit, "exercise after restart");
        join
        wait_for_tick(exercise_secs - secs_t'(1));
        fork
            press_button(btn_cancel);
            wait_for_state(phase_idle, '0, press_limit, "idle after cancel");
        join
        repeat (triple_cycles) @(negedge clk);
        check_value("buzzer_o bursts", 0, burst_count);

        // Start with a zero count needs a setting that maps to zero
        for (int i = 0; i < 256; i++) begin
            if (!zero_found && expected_count(settings_t'(i[7:0])) == '0) begin
                zero_found    = 1'b1;
                zero_settings = settings_t'(i[7:0]);
            end
        end
        if (zero_found) begin
            @(posedge clk);
            #2;
            settings = zero_settings;
            press_button(btn_start);
            @(negedge clk);
            check_value("count_o", 0, count);
            check_value("status_o.phase", phase_idle, status.phase);
        end

        @(negedge clk);
        wait (chk_name.size() == 0);
        @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/fitness_chk.sv
// Sequencer assertions, bound into every workout_seq instance.
// Checks hold only outside reset.
`default_nettype none

module fitness_chk
    import fitness_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input seq_status_t status_i,
    input beep_req_t   beep_i,
    input count_t      session_count_i
);

    // One pattern per request
    a_single_beep: assert property (@(posedge clk) disable iff (rst)
        !(beep_i.short_beep && beep_i.long_beep))
        else $error("Short and long beep requested in the same cycle");

    a_timer_range: assert property (@(posedge clk) disable iff (rst)
        status_i.timer <= exercise_secs)
        else $error("Period timer above the exercise length");

    a_index_range: assert property (@(posedge clk) disable iff (rst)
        status_i.phase != phase_idle |-> status_i.index < session_count_i)
        else $error("Exercise index reached the latched count");

endmodule

bind workout_seq fitness_chk u_seq_chk (
    .clk             (clk),
    .rst             (rst),
    .status_i        (status_q),
    .beep_i          (beep_q),
    .session_count_i (session_count)
);

`default_nettype wire

//--- hw/fitness_top.sv
// Fitness training scheduler top level.
// Buttons are active low and expected synchronous to clk.
// Timing parameters default to the 50 MHz board values.
`default_nettype none

module fitness_top
    import fitness_pkg::*;
#(
    parameter int unsigned tick_cycles     = default_tick_cycles,
    parameter int unsigned debounce_cycles = default_debounce_cycles,
    parameter int unsigned beep_unit       = default_beep_unit,
    parameter int unsigned tone_div        = default_tone_div
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_n_i,
    input  logic        skip_n_i,
    input  logic        cancel_n_i,
    input  settings_t   settings_i,
    output count_t      count_o,
    output seq_status_t status_o,
    output logic        buzzer_o
);
    logic      start_press;
    logic      skip_press;
    logic      cancel_press;
    logic      tick;
    beep_req_t beep_req;

    button_cond #(.debounce_cycles(debounce_cycles)) u_start_btn (
        .clk(clk), .rst(rst), .btn_n_i(start_n_i), .press_o(start_press)
    );
    button_cond #(.debounce_cycles(debounce_cycles)) u_skip_btn (
        .clk(clk), .rst(rst), .btn_n_i(skip_n_i), .press_o(skip_press)
    );
    button_cond #(.debounce_cycles(debounce_cycles)) u_cancel_btn (
        .clk(clk), .rst(rst), .btn_n_i(cancel_n_i), .press_o(cancel_press)
    );

    tick_gen #(.tick_cycles(tick_cycles)) u_tick (
        .clk(clk), .rst(rst), .tick_o(tick)
    );

    workout_count u_count (
        .clk(clk), .rst(rst), .settings_i(settings_i), .count_o(count_o)
    );

    workout_seq u_seq (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start_press),
        .skip_i   (skip_press),
        .cancel_i (cancel_press),
        .tick_i   (tick),
        .count_i  (count_o),
        .status_o (status_o),
        .beep_o   (beep_req)
    );

    beep_gen #(.beep_unit(beep_unit), .tone_div(tone_div)) u_beep (
        .clk(clk), .rst(rst), .beep_i(beep_req), .buzzer_o(buzzer_o)
    );

endmodule

`default_nettype wire

//--- hw/beep_gen.sv
// Buzzer pattern player: three short beeps or one long beep.
// Requests arriving while a pattern plays are ignored.
// beep_unit and tone_div must be at least 1.
`default_nettype none

module beep_gen
    import fitness_pkg::*;
#(
    parameter int unsigned beep_unit = 2_500_000,
    parameter int unsigned tone_div  = 25_000
) (
    input  logic      clk,
    input  logic      rst,
    input  beep_req_t beep_i,
    output logic      buzzer_o
);
    typedef enum logic [2:0] {
        st_silent,
        st_beep1,
        st_pause1,
        st_beep2,
        st_pause2,
        st_beep3,
        st_long_beep
    } beep_state_t;

    beep_state_t state_q;
    beep_state_t state_after;   // Where the current step leads
    logic [31:0] dur_q;         // Cycles left in this step, minus one
    logic [31:0] div_q;
    logic        tone_q;
    logic        sounding;

    always_comb begin
        case (state_q)
            st_beep1:  state_after = st_pause1;
            st_pause1: state_after = st_beep2;
            st_beep2:  state_after = st_pause2;
            st_pause2: state_after = st_beep3;
            default:   state_after = st_silent;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= st_silent;
            dur_q   <= '0;
        end else if (state_q == st_silent) begin
            if (beep_i.long_beep) begin             // Long wins over short
                state_q <= st_long_beep;
                dur_q   <= long_beep_units * beep_unit - 1;
            end else if (beep_i.short_beep) begin
                state_q <= st_beep1;
                dur_q   <= beep_unit - 1;
            end
        end else if (dur_q != '0) begin
            dur_q <= dur_q - 32'd1;
        end else begin
            state_q <= state_after;
            dur_q   <= beep_unit - 1;
        end
    end

    assign sounding = (state_q == st_beep1) || (state_q == st_beep2) ||
                      (state_q == st_beep3) || (state_q == st_long_beep);

    // Square wave, starts high at each beep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q  <= '0;
            tone_q <= 1'b1;
        end else if (!sounding) begin
            div_q  <= '0;
            tone_q <= 1'b1;
        end else if (div_q == tone_div - 1) begin
            div_q  <= '0;
            tone_q <= ~tone_q;
        end else begin
            div_q <= div_q + 32'd1;
        end
    end

    assign buzzer_o = tone_q & sounding;

endmodule

`default_nettype wire

//--- hw/workout_seq.sv
// Session sequencer: exercise and rest periods timed by the one-second tick.
// Beep requests are single-cycle and may be dropped by the buzzer.
// The count is latched at start; settings changes during a session are ignored.
`default_nettype none

module workout_seq
    import fitness_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        skip_i,
    input  logic        cancel_i,
    input  logic        tick_i,
    input  count_t      count_i,
    output seq_status_t status_o,
    output beep_req_t   beep_o
);
    seq_status_t status_q;
    seq_status_t status_d;
    count_t      session_count;    // Count latched at start
    count_t      session_count_d;
    beep_req_t   beep_q;
    beep_req_t   beep_d;
    logic        advance;          // Current period done, move on
    logic        go_idle;
    logic        last_exercise;

    assign last_exercise = (status_q.index == session_count - count_t'(1));

    always_comb begin
        status_d        = status_q;
        session_count_d = session_count;
        beep_d          = '0;
        advance         = 1'b0;
        go_idle         = 1'b0;

        if (cancel_i) begin
            go_idle = 1'b1;                         // Quiet abort
        end else begin
            case (status_q.phase)
                phase_idle: begin
                    if (start_i && count_i != '0) begin
                        session_count_d = count_i;
                        status_d.phase  = phase_exercise;
                    end
                end
                phase_exercise: begin
                    if (tick_i) begin
                        if (status_q.timer == secs_t'(1)) begin
                            status_d.phase    = phase_rest;
                            status_d.timer    = rest_secs;
                            beep_d.short_beep = 1'b1;
                        end else begin
                            status_d.timer = status_q.timer - secs_t'(1);
                        end
                    end else if (skip_i) begin
                        advance = 1'b1;
                    end
                end
                phase_rest: begin
                    if (tick_i && status_q.timer != secs_t'(1)) begin
                        status_d.timer = status_q.timer - secs_t'(1);
                    end else if (tick_i || skip_i) begin
                        advance = 1'b1;
                    end
                end
                default: go_idle = 1'b1;
            endcase
        end

        // End of rest or a skip: next exercise, or finish on the last one
        if (advance && last_exercise) begin
            go_idle          = 1'b1;
            beep_d.long_beep = 1'b1;
        end else if (advance) begin
            status_d.phase    = phase_exercise;
            status_d.timer    = exercise_secs;
            status_d.index    = status_q.index + count_t'(1);
            beep_d.short_beep = 1'b1;
        end

        if (go_idle) begin
            status_d.phase = phase_idle;
            status_d.timer = exercise_secs;
            status_d.index = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_q      <= '{phase: phase_idle, timer: exercise_secs, index: '0};
            session_count <= '0;
            beep_q        <= '0;
        end else begin
            status_q      <= status_d;
            session_count <= session_count_d;
            beep_q        <= beep_d;
        end
    end

    assign status_o = status_q;
    assign beep_o   = beep_q;

endmodule

`default_nettype wire

//--- hw/workout_count.sv
// Exercise count from the settings, registered once.
// Female adds one eighth of the base, then met shifts the sum right.
`default_nettype none

module workout_count
    import fitness_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  settings_t settings_i,
    output count_t    count_o
);
    logic [7:0] base_count;
    count_t     scaled_count;

    assign base_count = base_count_table[{settings_i.weight, settings_i.calories}];

    // Max 240 + 30 still fits the 9-bit count
    always_comb begin
        if (settings_i.female) begin
            scaled_count = {1'b0, base_count} + {4'b0000, base_count[7:3]};
        end else begin
            scaled_count = {1'b0, base_count};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count_o <= '0;
        end else begin
            count_o <= scaled_count >> settings_i.met;
        end
    end

endmodule

`default_nettype wire

//--- hw/tick_gen.sv
// One-cycle tick every tick_cycles clock cycles, tick_cycles must be at least 1
`default_nettype none

module tick_gen #(
    parameter int unsigned tick_cycles = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic tick_o
);
    logic [31:0] div_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick_o  <= 1'b0;
        end else if (div_cnt == tick_cycles - 1) begin
            div_cnt <= '0;
            tick_o  <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 32'd1;
            tick_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/button_cond.sv
// Debounce and press detection for one active-low push button.
// The raw input is assumed synchronous to clk; no synchronizer stages.
`default_nettype none

module button_cond #(
    parameter int unsigned debounce_cycles = 250_000
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_n_i,
    output logic press_o
);
    logic [31:0] stable_cnt;
    logic        level_n;     // Debounced raw level, released is high
    logic        pressed_q;

    // New level is adopted after it held for debounce_cycles+1 samples
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stable_cnt <= '0;
            level_n    <= 1'b1;
        end else if (btn_n_i == level_n) begin
            stable_cnt <= '0;
        end else if (stable_cnt == debounce_cycles) begin
            stable_cnt <= '0;
            level_n    <= btn_n_i;
        end else begin
            stable_cnt <= stable_cnt + 32'd1;
        end
    end

    // Rising edge of the pressed level
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pressed_q <= 1'b0;
            press_o   <= 1'b0;
        end else begin
            pressed_q <= ~level_n;
            press_o   <= ~level_n & ~pressed_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/fitness_pkg.sv
// Shared widths, types and constants of the fitness scheduler.
// Timing defaults assume a 50 MHz board clock.
`default_nettype none

package fitness_pkg;

    typedef logic [2:0] weight_t;   // Body weight class
    typedef logic [1:0] calorie_t;  // Calorie goal
    typedef logic [1:0] met_t;      // Intensity, used as right-shift amount
    typedef logic [8:0] count_t;    // Exercise count and exercise index
    typedef logic [5:0] secs_t;     // Period timer in seconds

    typedef struct packed {
        weight_t  weight;
        calorie_t calories;
        met_t     met;
        logic     female;
    } settings_t;

    typedef enum logic [1:0] {
        phase_idle,
        phase_exercise,
        phase_rest
    } phase_t;

    typedef struct packed {
        phase_t phase;
        secs_t  timer;
        count_t index;
    } seq_status_t;

    typedef struct packed {
        logic short_beep;
        logic long_beep;
    } beep_req_t;

    // Base exercise count, indexed by {weight, calories}
    localparam logic [7:0] base_count_table [32] = '{
        8'd60, 8'd120, 8'd180, 8'd240,
        8'd50, 8'd100, 8'd150, 8'd200,
        8'd43, 8'd86,  8'd129, 8'd171,
        8'd38, 8'd75,  8'd113, 8'd150,
        8'd33, 8'd67,  8'd100, 8'd133,
        8'd30, 8'd60,  8'd90,  8'd120,
        8'd27, 8'd55,  8'd82,  8'd109,
        8'd25, 8'd50,  8'd75,  8'd100
    };

    localparam secs_t exercise_secs = 6'd45;
    localparam secs_t rest_secs     = 6'd15;

    // Board timing at 50 MHz
    localparam int unsigned default_tick_cycles     = 32'd50_000_000;  // One second
    localparam int unsigned default_debounce_cycles = 32'd250_000;     // 5 ms
    localparam int unsigned default_beep_unit       = 32'd2_500_000;   // 50 ms
    localparam int unsigned default_tone_div        = 32'd25_000;      // 1 kHz tone

    // Long beep length in beep units
    localparam int unsigned long_beep_units = 32'd12;

endpackage

`default_nettype wire
